//--- Bender.yml
package:
  name: settings_ctrl

sources:
  - include_dirs:
      - logic
    files:
      - logic/settings_ctrl_pkg.sv
      - logic/line_fifo.sv
      - logic/vita_cmd_parser.sv
      - logic/cmd_sequencer.sv
      - logic/ack_framer.sv
      - logic/settings_ctrl_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/settings_ctrl_tb.sv

//--- logic/ack_framer.sv
// ack packet framer

`timescale 1ns/1ps

`include "settings_ctrl_settings.svh"

module ack_framer (
    input  logic                           clock,
    input  logic                           reset,
    input  settings_ctrl_pkg::result_line_t res_rdata,
    input  logic                           res_empty,
    output logic                           res_read,
    output settings_ctrl_pkg::line_t        out_data,
    output logic                           out_valid,
    input  logic                           out_ready
);

    import settings_ctrl_pkg::*;

    frame_state_e state;

    word_t res_hdr;
    word_t res_data;
    word_t prot_hdr;
    word_t vrt_hdr;
    word_t out_word;
    logic  writing;
    logic  sof;
    logic  eof;

    assign {res_hdr, res_data} = res_rdata;

    assign out_valid = !res_empty;
    assign writing   = out_valid && out_ready;

    // release the result once its last line is taken
    assign res_read = writing && (state == WR_RB_DATA);

    // 16 bytes follow, framed, with the destination above
    assign prot_hdr = {13'd0, `SETTINGS_CTRL_PROT_DEST, 1'b1, 16'd16};

    // packet type code, the command's sequence nibble and 4 words
    assign vrt_hdr = {12'h500, res_hdr[19:16], 16'd4};

    always_comb begin
        case (state)
            WR_PROT_HDR: out_word = prot_hdr;
            WR_VRT_HDR:  out_word = vrt_hdr;
            WR_VRT_SID:  out_word = `SETTINGS_CTRL_ACK_SID;
            WR_RB_HDR:   out_word = res_hdr;
            WR_RB_DATA:  out_word = res_data;
            default:     out_word = '0;
        endcase
    end

    assign sof = (state == WR_PROT_HDR);
    assign eof = (state == WR_RB_DATA);
    assign out_data = {2'b00, eof, sof, out_word};

    // advance one line per transfer
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= WR_PROT_HDR;
        end else if (writing) begin
            case (state)
                WR_PROT_HDR: state <= WR_VRT_HDR;
                WR_VRT_HDR:  state <= WR_VRT_SID;
                WR_VRT_SID:  state <= WR_RB_HDR;
                WR_RB_HDR:   state <= WR_RB_DATA;
                default:     state <= WR_PROT_HDR;
            endcase
        end
    end

endmodule

//--- logic/cmd_sequencer.sv
// command sequencer and settings bus

`timescale 1ns/1ps

module cmd_sequencer (
    input  logic                           clock,
    input  logic                           reset,
    input  settings_ctrl_pkg::cmd_line_t    cmd_rdata,
    input  logic                           cmd_empty,
    output logic                           cmd_read,
    output settings_ctrl_pkg::result_line_t res_wdata,
    output logic                           res_write,
    input  logic                           res_full,
    input  logic                           perfs_ready,
    input  settings_ctrl_pkg::ticks_t       vita_time,
    input  settings_ctrl_pkg::word_t        readback_words [16],
    output logic                           strobe,
    output settings_ctrl_pkg::set_addr_t    addr,
    output settings_ctrl_pkg::word_t        data
);

    import settings_ctrl_pkg::*;

    seq_state_e state;

    ticks_t head_ticks;
    word_t  head_hdr;
    word_t  head_data;
    logic   head_has_time;

    ticks_t ticks_reg;
    word_t  hdr_reg;
    word_t  data_reg;
    word_t  rb_data;
    logic   time_ready;
    logic   action;

    // split the FIFO head into its fields
    assign {head_ticks, head_hdr, head_data, head_has_time} = cmd_rdata;

    // ------------------------------
    // action condition
    // ------------------------------

    // head stays in the FIFO until the action, so the flag is read from it
    // timed commands wait until system time is at or past the ticks
    assign time_ready = !head_has_time || (vita_time >= ticks_reg);
    assign action = (state == EVENT_CMD) && !res_full && perfs_ready && time_ready;

    // pop the command and push its result on the same cycle
    assign cmd_read  = action;
    assign res_write = action;
    assign res_wdata = {hdr_reg, rb_data};

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= LOAD_CMD;
        end else begin
            case (state)
                LOAD_CMD:  if (!cmd_empty) state <= EVENT_CMD;
                EVENT_CMD: if (action) state <= LOAD_CMD;
                default:   state <= LOAD_CMD;
            endcase
        end
    end

    // hold the head command while waiting
    always_ff @(posedge clock) begin
        if (state == LOAD_CMD) begin
            ticks_reg <= head_ticks;
            hdr_reg   <= head_hdr;
            data_reg  <= head_data;
        end
    end

    // ------------------------------
    // readback mux
    // ------------------------------

    // sampled every cycle so the result sees the latest word
    always_ff @(posedge clock) begin
        rb_data <= readback_words[head_hdr[3:0]];
    end

    // ------------------------------
    // settings bus
    // ------------------------------

    // one cycle pulse after a poke action
    always_ff @(posedge clock) begin
        if (reset) begin
            strobe <= 1'b0;
        end else begin
            strobe <= action && hdr_reg[8];
        end
    end

    assign addr = hdr_reg[7:0];
    assign data = data_reg;

endmodule

//--- logic/line_fifo.sv
// first word fall through FIFO

`timescale 1ns/1ps

module line_fifo #(
    parameter int WIDTH = 64,
    parameter int DEPTH_LOG2 = 2
) (
    input  logic             clock,
    input  logic             reset,
    input  logic [WIDTH-1:0] wdata,
    input  logic             write,
    output logic             full,
    output logic [WIDTH-1:0] rdata,
    input  logic             read,
    output logic             empty
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2:0]   count;
    logic                  do_write;
    logic                  do_read;

    // writes when full and reads when empty are dropped
    assign do_write = write && !full;
    assign do_read  = read && !empty;

    assign full  = (count == DEPTH[DEPTH_LOG2:0]);
    assign empty = (count == '0);

    // head entry is always on the output
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // pointers wrap naturally at the power of two depth
    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + do_write - do_read;
        end
    end

endmodule

//--- logic/settings_ctrl_pkg.sv
// settings controller types

package settings_ctrl_pkg;

    // one stream line with eof in bit 33 and sof in bit 32
    typedef logic [35:0] line_t;
    typedef logic [31:0] word_t;
    typedef logic [63:0] ticks_t;
    typedef logic [7:0] set_addr_t;

    // {ticks, header, data, has_time}
    typedef logic [128:0] cmd_line_t;

    // {header, readback data}
    typedef logic [63:0] result_line_t;

    // input parser walking the vrt header
    typedef enum logic [3:0] {
        LINE0, VRT_HDR, VRT_SID, VRT_CID0, VRT_CID1, VRT_TSI,
        VRT_TSF0, VRT_TSF1, CMD_HDR, CMD_DATA, WAIT_EOF, STORE_CMD
    } parse_state_e;

    typedef enum logic {
        LOAD_CMD, EVENT_CMD
    } seq_state_e;

    // ack framer, one state per output line
    typedef enum logic [2:0] {
        WR_PROT_HDR, WR_VRT_HDR, WR_VRT_SID, WR_RB_HDR, WR_RB_DATA
    } frame_state_e;

endpackage

//--- logic/settings_ctrl_settings.svh
// settings controller build settings

`ifndef SETTINGS_CTRL_SETTINGS_SVH
`define SETTINGS_CTRL_SETTINGS_SVH

// ------------------------------
// FIFO sizing
// ------------------------------

// log2 of the entry count of both command and result FIFOs
`define SETTINGS_CTRL_FIFO_LOG2 2

// ------------------------------
// ack packet fields
// ------------------------------

// destination field of the protocol header
`define SETTINGS_CTRL_PROT_DEST 2'd0

// stream id carried in every ack
`define SETTINGS_CTRL_ACK_SID 32'h0000_0000

`endif

//--- logic/settings_ctrl_top.sv
// settings and readback controller

`timescale 1ns/1ps

`include "settings_ctrl_settings.svh"

module settings_ctrl_top (
    input  logic                        clock,
    input  logic                        reset,
    input  settings_ctrl_pkg::line_t     in_data,
    input  logic                        in_valid,
    output logic                        in_ready,
    output settings_ctrl_pkg::line_t     out_data,
    output logic                        out_valid,
    input  logic                        out_ready,
    input  logic                        perfs_ready,
    input  settings_ctrl_pkg::ticks_t    vita_time,
    input  settings_ctrl_pkg::word_t     readback_words [16],
    output logic                        strobe,
    output settings_ctrl_pkg::set_addr_t addr,
    output settings_ctrl_pkg::word_t     data
);

    import settings_ctrl_pkg::*;

    // parser to command FIFO
    cmd_line_t cmd_wdata;
    logic      cmd_write;
    logic      cmd_full;

    // command FIFO to sequencer
    cmd_line_t cmd_rdata;
    logic      cmd_empty;
    logic      cmd_read;

    // sequencer to result FIFO
    result_line_t res_wdata;
    logic         res_write;
    logic         res_full;

    // result FIFO to framer
    result_line_t res_rdata;
    logic         res_empty;
    logic         res_read;

    // ------------------------------
    // command path
    // ------------------------------
    vita_cmd_parser vita_cmd_parser_i (
        .clock(clock),
        .reset(reset),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .cmd_wdata(cmd_wdata),
        .cmd_write(cmd_write),
        .cmd_full(cmd_full)
    );

    line_fifo #(
        .WIDTH($bits(cmd_line_t)),
        .DEPTH_LOG2(`SETTINGS_CTRL_FIFO_LOG2)
    ) cmd_fifo (
        .clock(clock),
        .reset(reset),
        .wdata(cmd_wdata),
        .write(cmd_write),
        .full(cmd_full),
        .rdata(cmd_rdata),
        .read(cmd_read),
        .empty(cmd_empty)
    );

    cmd_sequencer cmd_sequencer_i (
        .clock(clock),
        .reset(reset),
        .cmd_rdata(cmd_rdata),
        .cmd_empty(cmd_empty),
        .cmd_read(cmd_read),
        .res_wdata(res_wdata),
        .res_write(res_write),
        .res_full(res_full),
        .perfs_ready(perfs_ready),
        .vita_time(vita_time),
        .readback_words(readback_words),
        .strobe(strobe),
        .addr(addr),
        .data(data)
    );

    // ------------------------------
    // result path
    // ------------------------------
    line_fifo #(
        .WIDTH($bits(result_line_t)),
        .DEPTH_LOG2(`SETTINGS_CTRL_FIFO_LOG2)
    ) res_fifo (
        .clock(clock),
        .reset(reset),
        .wdata(res_wdata),
        .write(res_write),
        .full(res_full),
        .rdata(res_rdata),
        .read(res_read),
        .empty(res_empty)
    );

    ack_framer ack_framer_i (
        .clock(clock),
        .reset(reset),
        .res_rdata(res_rdata),
        .res_empty(res_empty),
        .res_read(res_read),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

//--- logic/vita_cmd_parser.sv
// vita command packet parser

`timescale 1ns/1ps

module vita_cmd_parser (
    input  logic                        clock,
    input  logic                        reset,
    input  settings_ctrl_pkg::line_t     in_data,
    input  logic                        in_valid,
    output logic                        in_ready,
    output settings_ctrl_pkg::cmd_line_t cmd_wdata,
    output logic                        cmd_write,
    input  logic                        cmd_full
);

    import settings_ctrl_pkg::*;

    parse_state_e state;

    ticks_t ticks_reg;
    word_t  hdr_reg;
    word_t  data_reg;
    logic   has_cid_reg;
    logic   has_tsi_reg;
    logic   has_tsf_reg;

    logic reading;
    logic eof;
    logic has_sid;
    logic has_cid;
    logic has_tsi;
    logic has_tsf;

    assign reading = in_valid && in_ready;
    assign eof     = in_data[33];

    // optional field flags straight from the vrt header word
    assign has_sid = in_data[28];
    assign has_cid = in_data[27];
    assign has_tsi = (in_data[23:22] != 2'b00);
    assign has_tsf = (in_data[21:20] != 2'b00);

    // stall the input only while the finished command waits for room
    assign in_ready  = (state != STORE_CMD);
    assign cmd_write = (state == STORE_CMD) && !cmd_full;
    assign cmd_wdata = {ticks_reg, hdr_reg, data_reg, has_tsf_reg};

    // ------------------------------
    // captured fields
    // ------------------------------
    always_ff @(posedge clock) begin
        if (reading) begin
            case (state)
                VRT_HDR: begin
                    has_cid_reg <= has_cid;
                    has_tsi_reg <= has_tsi;
                    has_tsf_reg <= has_tsf;
                end
                // ticks arrive high word first
                VRT_TSF0: ticks_reg[63:32] <= in_data[31:0];
                VRT_TSF1: ticks_reg[31:0]  <= in_data[31:0];
                CMD_HDR:  hdr_reg          <= in_data[31:0];
                CMD_DATA: data_reg         <= in_data[31:0];
                default: ;
            endcase
        end
    end

    // ------------------------------
    // header walk
    // ------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= LINE0;
        end else begin
            case (state)
                // protocol header line
                LINE0: if (reading) state <= VRT_HDR;
                VRT_HDR: begin
                    if (reading) begin
                        if (has_sid)      state <= VRT_SID;
                        else if (has_cid) state <= VRT_CID0;
                        else if (has_tsi) state <= VRT_TSI;
                        else if (has_tsf) state <= VRT_TSF0;
                        else              state <= CMD_HDR;
                    end
                end
                VRT_SID: begin
                    if (reading) begin
                        if (has_cid_reg)      state <= VRT_CID0;
                        else if (has_tsi_reg) state <= VRT_TSI;
                        else if (has_tsf_reg) state <= VRT_TSF0;
                        else                  state <= CMD_HDR;
                    end
                end
                VRT_CID0: if (reading) state <= VRT_CID1;
                VRT_CID1: begin
                    if (reading) begin
                        if (has_tsi_reg)      state <= VRT_TSI;
                        else if (has_tsf_reg) state <= VRT_TSF0;
                        else                  state <= CMD_HDR;
                    end
                end
                VRT_TSI: begin
                    if (reading) begin
                        state <= has_tsf_reg ? VRT_TSF0 : CMD_HDR;
                    end
                end
                VRT_TSF0: if (reading) state <= VRT_TSF1;
                VRT_TSF1: if (reading) state <= CMD_HDR;
                CMD_HDR:  if (reading) state <= CMD_DATA;
                // a short packet ends on the data word
                CMD_DATA: if (reading) state <= eof ? STORE_CMD : WAIT_EOF;
                WAIT_EOF: if (reading && eof) state <= STORE_CMD;
                STORE_CMD: if (!cmd_full) state <= LINE0;
                default: state <= LINE0;
            endcase
        end
    end

endmodule

//--- sim.f
+incdir+logic
logic/settings_ctrl_pkg.sv
logic/line_fifo.sv
logic/vita_cmd_parser.sv
logic/cmd_sequencer.sv
logic/ack_framer.sv
logic/settings_ctrl_top.sv
verification/settings_ctrl_tb.sv

//--- verification/settings_ctrl_tb.sv
// settings controller testbench

`timescale 1ns/1ps

`include "settings_ctrl_settings.svh"

module settings_ctrl_tb;

    import settings_ctrl_pkg::*;

    localparam int T_POKE = 0;
    localparam int T_PEEK = 1;
    localparam int T_OPTS = 2;
    localparam int T_TIMED = 3;
    localparam int T_HOLD = 4;
    localparam int T_BP = 5;

    // run length used by the watchdog
    localparam int PACKET_COUNT = 35;
    localparam int PACKET_BUDGET = 150;
    localparam int FUTURE_TICKS = 60;
    localparam int HOLD_CYCLES = 50;

    logic clock;
    logic reset;
    line_t in_data;
    logic in_valid;
    logic in_ready;
    line_t out_data;
    logic out_valid;
    logic out_ready;
    logic perfs_ready;
    ticks_t vita_time;
    word_t readback_words [16];
    logic strobe;
    set_addr_t addr;
    word_t data;

    logic [15:0] lfsr;
    logic [15:0] ready_lfsr;
    logic bp_mode;
    logic hold_active;
    logic saw_stall;
    int cycle;
    int last_strobe_cycle;
    int sent_cycle;
    string cmp_name;
    logic cmp_timed;
    ticks_t cmp_ticks;

    // expected ack lines and strobe records
    line_t ack_q[$];
    int ack_test_q[$];
    set_addr_t s_addr_q[$];
    word_t s_data_q[$];
    ticks_t s_ticks_q[$];
    logic s_timed_q[$];
    int s_test_q[$];

    word_t pkt[$];

    settings_ctrl_top settings_ctrl_top_i (
        .clock(clock),
        .reset(reset),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .perfs_ready(perfs_ready),
        .vita_time(vita_time),
        .readback_words(readback_words),
        .strobe(strobe),
        .addr(addr),
        .data(data)
    );

    always #2 clock = ~clock;

    // ------------------------------
    // helpers
    // ------------------------------

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            T_POKE:  return "poke_untimed";
            T_PEEK:  return "peek_readback";
            T_OPTS:  return "header_options";
            T_TIMED: return "timed_command";
            T_HOLD:  return "perfs_hold";
            default: return "backpressure";
        endcase
    endfunction

    // expected ack line k for a command header
    function automatic line_t ack_line(input word_t hdr, input int k);
        case (k)
            0: return {4'b0001, 13'd0, `SETTINGS_CTRL_PROT_DEST, 1'b1, 16'd16};
            1: return {4'b0000, 12'h500, hdr[19:16], 16'd4};
            2: return {4'b0000, `SETTINGS_CTRL_ACK_SID};
            3: return {4'b0000, hdr};
            default: return {4'b0010, readback_words[hdr[3:0]]};
        endcase
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    task automatic expect_command(input int test, input word_t hdr, input word_t dat,
                                  input logic tsf, input ticks_t ticks);
        for (int k = 0; k < 5; k++) begin
            ack_q.push_back(ack_line(hdr, k));
            ack_test_q.push_back(test);
        end
        // only pokes reach the settings bus
        if (hdr[8]) begin
            s_addr_q.push_back(hdr[7:0]);
            s_data_q.push_back(dat);
            s_ticks_q.push_back(ticks);
            s_timed_q.push_back(tsf);
            s_test_q.push_back(test);
        end
    endtask

    // build one vita command packet and drive it line by line
    task automatic send_command(input int test, input word_t hdr, input word_t dat,
                                input logic sid, input logic cid, input logic tsi,
                                input logic tsf, input ticks_t ticks, input int extra,
                                input logic gaps);
        expect_command(test, hdr, dat, tsf, ticks);
        pkt.delete();
        pkt.push_back(32'h0001_0000 | rand_bits(16));
        pkt.push_back({3'b000, sid, cid, 3'b000, tsi, 1'b0, 1'b0, tsf, 4'h0, 16'd0});
        if (sid) pkt.push_back(rand_bits(32));
        if (cid) begin
            pkt.push_back(rand_bits(32));
            pkt.push_back(rand_bits(32));
        end
        if (tsi) pkt.push_back(rand_bits(32));
        if (tsf) begin
            pkt.push_back(ticks[63:32]);
            pkt.push_back(ticks[31:0]);
        end
        pkt.push_back(hdr);
        pkt.push_back(dat);
        for (int e = 0; e < extra; e++) begin
            pkt.push_back(rand_bits(32));
        end
        @(posedge clock);
        for (int i = 0; i < pkt.size(); i++) begin
            if (gaps && rand_bits(2) == 0) begin
                in_valid <= 1'b0;
                repeat (rand_bits(2) + 1) @(posedge clock);
            end
            in_data <= {2'b00, i == pkt.size() - 1, i == 0, pkt[i]};
            in_valid <= 1'b1;
            do @(negedge clock); while (!in_ready);
            @(posedge clock);
        end
        in_valid <= 1'b0;
    endtask

    task automatic send_random(input int test, input logic allow_tsf, input logic gaps);
        word_t hdr;
        word_t dat;
        logic tsf;
        hdr = rand_bits(32);
        dat = rand_bits(32);
        tsf = allow_tsf && rand_bits(1);
        send_command(test, hdr, dat, rand_bits(1), rand_bits(1), rand_bits(1), tsf,
                     {32'd0, rand_bits(8)}, rand_bits(2), gaps);
    endtask

    task automatic wait_drain();
        while (ack_q.size() != 0 || s_addr_q.size() != 0) @(negedge clock);
    endtask

    // ------------------------------
    // free running stimulus
    // ------------------------------
    always @(posedge clock) begin
        cycle <= cycle + 1;
        vita_time <= vita_time + 1;
        for (int i = 0; i < 4; i++) begin
            ready_lfsr = lfsr_step(ready_lfsr);
        end
        // sink takes a line about one cycle in sixteen under back-pressure
        if (bp_mode) out_ready <= (ready_lfsr[3:0] == 4'h0);
        else out_ready <= 1'b1;
    end

    // ------------------------------
    // comparator
    // ------------------------------
    always @(negedge clock) begin
        if (!reset) begin
            if (in_valid && !in_ready) saw_stall = 1'b1;
            if (hold_active) begin
                check("perfs_hold", 0, strobe);
                check("perfs_hold", 0, out_valid);
            end
            if (strobe) begin
                last_strobe_cycle = cycle;
                check("strobe_pending", 1, s_addr_q.size() != 0);
                cmp_name = test_name(s_test_q.pop_front());
                check(cmp_name, s_addr_q.pop_front(), addr);
                check(cmp_name, s_data_q.pop_front(), data);
                cmp_ticks = s_ticks_q.pop_front();
                cmp_timed = s_timed_q.pop_front();
                // timed strobe never ahead of system time
                if (cmp_timed) check(cmp_name, 1, vita_time >= cmp_ticks);
            end
            if (out_valid && out_ready) begin
                check("ack_pending", 1, ack_q.size() != 0);
                cmp_name = test_name(ack_test_q.pop_front());
                check(cmp_name, ack_q.pop_front(), out_data);
            end
        end
    end

    // watchdog
    initial begin
        repeat (PACKET_COUNT * PACKET_BUDGET + FUTURE_TICKS + HOLD_CYCLES) @(posedge clock);
        $display("timeout: the DUT stopped delivering strobes or ack lines");
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        clock = 1'b0;
        reset = 1'b1;
        in_data = '0;
        in_valid = 1'b0;
        out_ready = 1'b1;
        perfs_ready = 1'b1;
        vita_time = '0;
        lfsr = 16'd41;
        ready_lfsr = 16'd41;
        bp_mode = 1'b0;
        hold_active = 1'b0;
        saw_stall = 1'b0;
        cycle = 0;
        last_strobe_cycle = 0;
        sent_cycle = 0;
        for (int i = 0; i < 16; i++) begin
            readback_words[i] = 32'hB00C_0000 + 32'h0101_0000 * i + i;
        end
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check("reset_state", 0, strobe);
        check("reset_state", 0, out_valid);
        check("reset_state", 1, in_ready);

        for (int n = 0; n < 3; n++) begin
            send_command(T_POKE, rand_bits(32) | 32'h100, rand_bits(32),
                         0, 0, 0, 0, '0, 0, 0);
        end
        wait_drain();

        for (int n = 0; n < 3; n++) begin
            send_command(T_PEEK, rand_bits(32) & ~32'h100, rand_bits(32),
                         0, 0, 0, 0, '0, 0, 0);
        end
        wait_drain();

        for (int n = 0; n < 8; n++) begin
            send_random(T_OPTS, 0, 0);
        end
        wait_drain();

        // future tick value holds the strobe back
        send_command(T_TIMED, rand_bits(32) | 32'h100, rand_bits(32), 0, 0, 0, 1,
                     vita_time + FUTURE_TICKS, 0, 0);
        wait_drain();
        // past tick value fires at once
        send_command(T_TIMED, rand_bits(32) | 32'h100, rand_bits(32), 0, 0, 0, 1,
                     64'd2, 0, 0);
        sent_cycle = cycle;
        wait_drain();
        check("timed_command", 1,
              last_strobe_cycle > sent_cycle && last_strobe_cycle - sent_cycle < 12);

        @(posedge clock);
        perfs_ready <= 1'b0;
        hold_active = 1'b1;
        for (int n = 0; n < 3; n++) begin
            send_command(T_HOLD, rand_bits(32) | 32'h100, rand_bits(32),
                         0, 0, 0, 0, '0, 0, 0);
        end
        repeat (HOLD_CYCLES) @(posedge clock);
        hold_active = 1'b0;
        perfs_ready <= 1'b1;
        wait_drain();

        bp_mode = 1'b1;
        saw_stall = 1'b0;
        for (int n = 0; n < 16; n++) begin
            send_random(T_BP, 1, 1);
        end
        wait_drain();
        bp_mode = 1'b0;
        check("backpressure", 1, saw_stall);

        repeat (10) @(posedge clock);
        check("final_idle", 0, out_valid);
        $display("TESTS PASSED");
        $finish;
    end

endmodule
